//--- logic/net_pkg.sv
package net_pkg;

    // one address compared as a word and serialised or captured as bytes
    // bytes[3] is the first byte on the wire
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } ip_addr_u;

    localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
    localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;

    localparam logic [15:0] ARP_OP_REQUEST = 16'h0001;
    localparam logic [15:0] ARP_OP_REPLY   = 16'h0002;

    localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0]  SFD_BYTE       = 8'hd5;

    localparam int MIN_PAYLOAD = 46; // shorter bodies get zero padding
    localparam int IP_HDR_LEN  = 20;
    localparam int UDP_HDR_LEN = 8;

    localparam logic [7:0]  IP_TTL = 8'd128;

    // reflected form since the CRC register shifts lsb first
    localparam logic [31:0] CRC_RESIDUE_POLY = 32'hedb8_8320;

endpackage

//--- logic/seg_pkg.sv
package seg_pkg;

    // byte counts and RAM addresses
    localparam int LEN_W = 16;

    // frame kind requested by the controller
    localparam logic FRAME_ARP = 1'b0;
    localparam logic FRAME_UDP = 1'b1;

endpackage

//--- logic/udp_tx_ctrl.sv
`timescale 1ns/10ps

module udp_tx_ctrl import seg_pkg::*; #(
    parameter int MAX_PAYLOAD = 1400,
    parameter int GAP_CYCLES  = 125,
    parameter int ARP_TIMEOUT = 1250000
) (
    input  logic             gmii_tx_clk,
    input  logic             rst_n,
    input  logic             tx_send_i,
    input  logic [LEN_W-1:0] tx_len_i,
    input  logic [LEN_W-1:0] tx_addr_i,
    input  logic             mac_valid_i,
    input  logic             arp_found_i,
    input  logic             frame_done_i,
    output logic             frame_start_o,
    output logic             frame_kind_o,
    output logic [LEN_W-1:0] seg_len_o,
    output logic [LEN_W-1:0] seg_addr_o,
    output logic             tx_done_o
);

    localparam logic [2:0] IDLE     = 3'd0;
    localparam logic [2:0] ARP_SEND = 3'd1;
    localparam logic [2:0] ARP_WAIT = 3'd2;
    localparam logic [2:0] SEG_CALC = 3'd3;
    localparam logic [2:0] SEND     = 3'd4;
    localparam logic [2:0] GAP      = 3'd5;

    localparam logic [LEN_W-1:0] MAX_SEG  = LEN_W'(MAX_PAYLOAD);
    localparam logic [31:0]      GAP_LAST = 32'(GAP_CYCLES - 1);
    localparam logic [31:0]      ARP_LAST = 32'(ARP_TIMEOUT - 1);

    logic [2:0]       state;
    logic [2:0]       send_q;
    logic             send_rise;
    logic             arp_hit;
    logic [31:0]      wait_cnt;
    logic [LEN_W-1:0] remain;
    logic [LEN_W-1:0] next_addr;
    logic [LEN_W-1:0] seg_next;

    assign send_rise = send_q[1] && !send_q[2]; // after the 2-flop sync
    assign seg_next  = (remain > MAX_SEG) ? MAX_SEG : remain;

    always_ff @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= IDLE;
            send_q        <= 3'b000;
            arp_hit       <= 1'b0;
            wait_cnt      <= '0;
            frame_start_o <= 1'b0;
            frame_kind_o  <= FRAME_ARP;
            tx_done_o     <= 1'b0;
        end
        else
        begin
            send_q        <= {send_q[1:0], tx_send_i};
            frame_start_o <= 1'b0;
            if (arp_found_i)
                arp_hit <= 1'b1;

            case (state)
                IDLE:
                begin
                    if (send_rise)
                    begin
                        tx_done_o <= 1'b0;
                        if (!mac_valid_i && tx_len_i != '0)
                        begin
                            frame_start_o <= 1'b1; // resolve the peer first
                            frame_kind_o  <= FRAME_ARP;
                            arp_hit       <= 1'b0;
                            state         <= ARP_SEND;
                        end
                        else
                            state <= SEG_CALC;
                    end
                end
                ARP_SEND:
                begin
                    wait_cnt <= '0;
                    if (frame_done_i)
                        state <= ARP_WAIT;
                end
                ARP_WAIT:
                begin
                    wait_cnt <= wait_cnt + 32'd1;
                    if (arp_hit && wait_cnt >= GAP_LAST)
                        state <= SEG_CALC;
                    else if (!arp_hit && wait_cnt == ARP_LAST)
                    begin
                        frame_start_o <= 1'b1; // no reply so ask again
                        frame_kind_o  <= FRAME_ARP;
                        state         <= ARP_SEND;
                    end
                end
                SEG_CALC:
                begin
                    if (remain == '0)
                    begin
                        tx_done_o <= 1'b1;
                        state     <= IDLE;
                    end
                    else
                    begin
                        frame_start_o <= 1'b1;
                        frame_kind_o  <= FRAME_UDP;
                        state         <= SEND;
                    end
                end
                SEND:
                begin
                    wait_cnt <= '0;
                    if (frame_done_i)
                        state <= GAP;
                end
                GAP:
                begin
                    wait_cnt <= wait_cnt + 32'd1;
                    if (wait_cnt == GAP_LAST)
                        state <= SEG_CALC;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // segment bookkeeping loaded with the frame_start pulse
    always_ff @(posedge gmii_tx_clk)
    begin
        if (state == IDLE && send_rise)
        begin
            remain    <= tx_len_i;
            next_addr <= tx_addr_i;
        end
        else if (state == SEG_CALC && remain != '0)
        begin
            seg_len_o  <= seg_next;
            seg_addr_o <= next_addr;
            remain     <= remain - seg_next;
            next_addr  <= next_addr + seg_next;
        end
    end

endmodule

//--- logic/frame_builder.sv
`timescale 1ns/10ps

module frame_builder import net_pkg::*, seg_pkg::*; #(
    parameter logic [47:0] LOCAL_MAC = 48'h000a_3501_fec0,
    parameter logic [31:0] LOCAL_IP  = 32'hc0a8_16c8,
    parameter logic [31:0] REMOTE_IP = 32'hc0a8_1664,
    parameter logic [15:0] UDP_PORT  = 16'h1f90
) (
    input  logic             gmii_tx_clk,
    input  logic             rst_n,
    input  logic             frame_start_i,
    input  logic             frame_kind_i,
    input  logic [LEN_W-1:0] seg_len_i,
    input  logic [LEN_W-1:0] seg_addr_i,
    input  logic [47:0]      remote_mac_i,
    input  logic [7:0]       tx_data_i,
    output logic [LEN_W-1:0] tx_addr_o,
    output logic             frame_done_o,
    output logic             gmii_tx_en_o,
    output logic [7:0]       gmii_txd_o
);

    localparam ip_addr_u LOCAL_IP_U  = LOCAL_IP;
    localparam ip_addr_u REMOTE_IP_U = REMOTE_IP;

    localparam logic [7:0] IP_PROTO_UDP = 8'd17;
    // ARP body and IPv4+UDP headers are both 28 bytes
    localparam logic [LEN_W-1:0] BODY_HDR  = LEN_W'(IP_HDR_LEN + UDP_HDR_LEN);
    localparam logic [LEN_W-1:0] HDR_END   = LEN_W'(8 + 14) + BODY_HDR;
    localparam logic [LEN_W-1:0] MIN_BODY  = LEN_W'(MIN_PAYLOAD);

    logic             active;
    logic             last_q;
    logic [LEN_W-1:0] cnt;
    logic [31:0]      crc_q;
    logic [15:0]      ident_q;
    logic [0:41][7:0] hdr_q;    // eth header + 28 body header bytes
    logic [LEN_W-1:0] pay_len;
    logic [LEN_W-1:0] body_len;
    logic [LEN_W-1:0] pay_end;
    logic [LEN_W-1:0] fcs_start;
    logic [LEN_W-1:0] last_cnt;
    logic [LEN_W-1:0] ip_total;
    logic [LEN_W-1:0] udp_len;
    logic [31:0]      csum;
    logic [15:0]      ip_csum;
    logic [5:0]       hdr_idx;
    logic [1:0]       fcs_idx;
    logic [7:0]       tx_byte;
    logic             crc_en;
    logic             addr_step;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++)
        begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ CRC_RESIDUE_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    assign pay_len   = (frame_kind_i == FRAME_UDP) ? seg_len_i : '0;
    assign body_len  = BODY_HDR + pay_len;
    assign pay_end   = HDR_END + pay_len;
    assign fcs_start = LEN_W'(8 + 14) + ((body_len < MIN_BODY) ? MIN_BODY : body_len);
    assign last_cnt  = fcs_start + LEN_W'(3);
    assign ip_total  = BODY_HDR + seg_len_i;
    assign udp_len   = LEN_W'(UDP_HDR_LEN) + seg_len_i;

    assign hdr_idx   = 6'(cnt - LEN_W'(8));
    assign fcs_idx   = 2'(cnt - fcs_start);
    assign crc_en    = cnt >= LEN_W'(8) && cnt < fcs_start;
    // address runs one byte ahead of the payload
    assign addr_step = cnt >= HDR_END - LEN_W'(1) && cnt + LEN_W'(2) < pay_end;

    always_comb
    begin
        csum = 32'h4500 + 32'(ip_total) + 32'(ident_q) + 32'h4000
             + {16'h0, IP_TTL, IP_PROTO_UDP}
             + {16'h0, LOCAL_IP_U.bytes[3], LOCAL_IP_U.bytes[2]}
             + {16'h0, LOCAL_IP_U.bytes[1], LOCAL_IP_U.bytes[0]}
             + {16'h0, REMOTE_IP_U.bytes[3], REMOTE_IP_U.bytes[2]}
             + {16'h0, REMOTE_IP_U.bytes[1], REMOTE_IP_U.bytes[0]};
        csum = {16'h0, csum[15:0]} + {16'h0, csum[31:16]}; // fold carries
        csum = {16'h0, csum[15:0]} + {16'h0, csum[31:16]};
        ip_csum = ~csum[15:0];
    end

    always_comb
    begin
        if (cnt < LEN_W'(7))
            tx_byte = PREAMBLE_BYTE;
        else if (cnt == LEN_W'(7))
            tx_byte = SFD_BYTE;
        else if (cnt < HDR_END)
            tx_byte = hdr_q[hdr_idx];
        else if (cnt < pay_end)
            tx_byte = tx_data_i;
        else if (cnt < fcs_start)
            tx_byte = 8'h00; // pad
        else
            tx_byte = ~crc_q[{fcs_idx, 3'b000} +: 8];
    end

    always_ff @(posedge gmii_tx_clk)
    begin
        if (frame_start_i)
        begin
            if (frame_kind_i == FRAME_UDP)
                hdr_q <= {remote_mac_i, LOCAL_MAC, ETH_TYPE_IPV4,
                          8'h45, 8'h00, ip_total, ident_q, 16'h4000, IP_TTL, IP_PROTO_UDP,
                          ip_csum, LOCAL_IP_U.bytes, REMOTE_IP_U.bytes,
                          UDP_PORT, UDP_PORT, udp_len, 16'h0000};
            else
                hdr_q <= {48'hffff_ffff_ffff, LOCAL_MAC, ETH_TYPE_ARP,
                          16'h0001, ETH_TYPE_IPV4, 8'd6, 8'd4, ARP_OP_REQUEST,
                          LOCAL_MAC, LOCAL_IP_U.bytes, 48'h0, REMOTE_IP_U.bytes};
        end
    end

    always_ff @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active       <= 1'b0;
            last_q       <= 1'b0;
            cnt          <= '0;
            crc_q        <= '1;
            ident_q      <= '0;
            tx_addr_o    <= '0;
            frame_done_o <= 1'b0;
            gmii_tx_en_o <= 1'b0;
            gmii_txd_o   <= 8'h00;
        end
        else
        begin
            last_q       <= 1'b0;
            frame_done_o <= last_q;
            if (frame_start_i)
            begin
                active <= 1'b1;
                cnt    <= '0;
                crc_q  <= '1;
                if (frame_kind_i == FRAME_UDP)
                begin
                    ident_q   <= ident_q + 16'd1;
                    tx_addr_o <= seg_addr_i;
                end
            end
            else if (active)
            begin
                cnt <= cnt + LEN_W'(1);
                if (crc_en)
                    crc_q <= crc_byte(crc_q, tx_byte);
                if (addr_step)
                    tx_addr_o <= tx_addr_o + LEN_W'(1);
                if (cnt == last_cnt)
                begin
                    active <= 1'b0;
                    last_q <= 1'b1;
                end
            end
            gmii_tx_en_o <= active;
            gmii_txd_o   <= active ? tx_byte : 8'h00;
        end
    end

endmodule

//--- logic/arp_rx_parser.sv
`timescale 1ns/10ps

module arp_rx_parser import net_pkg::*; #(
    parameter logic [31:0] LOCAL_IP  = 32'hc0a8_16c8,
    parameter logic [31:0] REMOTE_IP = 32'hc0a8_1664
) (
    input  logic        gmii_tx_clk,
    input  logic        rst_n,
    input  logic        gmii_rx_dv_i,
    input  logic [7:0]  gmii_rxd_i,
    output logic        arp_found_o,
    output logic [47:0] remote_mac_o,
    output logic        mac_valid_o
);

    logic        in_frame;
    logic        bad;
    logic [6:0]  idx;          // byte index after the SFD
    logic [7:0]  prev_b;
    logic [47:0] mac_shift;
    ip_addr_u    sender_ip;
    ip_addr_u    target_ip;
    logic        frame_end;
    logic        reply_ok;

    assign frame_end = in_frame && !gmii_rx_dv_i;
    assign reply_ok  = frame_end && !bad && idx >= 7'd42
                    && sender_ip.word == REMOTE_IP && target_ip.word == LOCAL_IP;

    always_ff @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_frame    <= 1'b0;
            bad         <= 1'b0;
            idx         <= '0;
            arp_found_o <= 1'b0;
            mac_valid_o <= 1'b0;
        end
        else
        begin
            arp_found_o <= reply_ok;
            if (reply_ok)
                mac_valid_o <= 1'b1;
            if (!gmii_rx_dv_i)
                in_frame <= 1'b0;
            else if (!in_frame)
            begin
                if (gmii_rxd_i == SFD_BYTE) // preamble skipped up to here
                begin
                    in_frame <= 1'b1;
                    idx      <= '0;
                    bad      <= 1'b0;
                end
            end
            else
            begin
                if (idx != '1)
                    idx <= idx + 7'd1;
                if (idx == 7'd13 && {prev_b, gmii_rxd_i} != ETH_TYPE_ARP)
                    bad <= 1'b1;
                if (idx == 7'd21 && {prev_b, gmii_rxd_i} != ARP_OP_REPLY)
                    bad <= 1'b1;
            end
        end
    end

    always_ff @(posedge gmii_tx_clk)
    begin
        prev_b <= gmii_rxd_i;
        if (in_frame && gmii_rx_dv_i)
        begin
            if (idx >= 7'd22 && idx <= 7'd27)
                mac_shift <= {mac_shift[39:0], gmii_rxd_i}; // sender MAC
            if (idx >= 7'd28 && idx <= 7'd31)
                sender_ip.bytes[2'd3 - 2'(idx - 7'd28)] <= gmii_rxd_i;
            if (idx >= 7'd38 && idx <= 7'd41)
                target_ip.bytes[2'd3 - 2'(idx - 7'd38)] <= gmii_rxd_i;
        end
        if (reply_ok)
            remote_mac_o <= mac_shift;
    end

endmodule

//--- logic/udp_mac_top.sv
`timescale 1ns/10ps

module udp_mac_top import seg_pkg::*; #(
    parameter logic [47:0] LOCAL_MAC   = 48'h000a_3501_fec0,
    parameter logic [31:0] LOCAL_IP    = 32'hc0a8_16c8,
    parameter logic [31:0] REMOTE_IP   = 32'hc0a8_1664,
    parameter logic [15:0] UDP_PORT    = 16'h1f90,
    parameter int          MAX_PAYLOAD = 1400,
    parameter int          GAP_CYCLES  = 125,
    parameter int          ARP_TIMEOUT = 1250000
) (
    input  logic             gmii_tx_clk,
    input  logic             rst_n,
    input  logic             tx_send_i,
    input  logic [LEN_W-1:0] tx_len_i,
    input  logic [LEN_W-1:0] tx_addr_i,
    input  logic [7:0]       tx_data_i,
    input  logic             gmii_rx_dv_i,
    input  logic [7:0]       gmii_rxd_i,
    output logic [LEN_W-1:0] tx_addr_o,
    output logic             tx_done_o,
    output logic             gmii_tx_en_o,
    output logic [7:0]       gmii_txd_o
);

    logic             frame_start;
    logic             frame_kind;
    logic [LEN_W-1:0] seg_len;
    logic [LEN_W-1:0] seg_addr;
    logic             frame_done;
    logic             arp_found;
    logic [47:0]      remote_mac;
    logic             mac_valid;

    udp_tx_ctrl #(
        .MAX_PAYLOAD (MAX_PAYLOAD),
        .GAP_CYCLES  (GAP_CYCLES),
        .ARP_TIMEOUT (ARP_TIMEOUT)
    ) udp_tx_ctrl_i (
        .gmii_tx_clk   (gmii_tx_clk),
        .rst_n         (rst_n),
        .tx_send_i     (tx_send_i),
        .tx_len_i      (tx_len_i),
        .tx_addr_i     (tx_addr_i),
        .mac_valid_i   (mac_valid),
        .arp_found_i   (arp_found),
        .frame_done_i  (frame_done),
        .frame_start_o (frame_start),
        .frame_kind_o  (frame_kind),
        .seg_len_o     (seg_len),
        .seg_addr_o    (seg_addr),
        .tx_done_o     (tx_done_o)
    );

    frame_builder #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .REMOTE_IP (REMOTE_IP),
        .UDP_PORT  (UDP_PORT)
    ) frame_builder_i (
        .gmii_tx_clk   (gmii_tx_clk),
        .rst_n         (rst_n),
        .frame_start_i (frame_start),
        .frame_kind_i  (frame_kind),
        .seg_len_i     (seg_len),
        .seg_addr_i    (seg_addr),
        .remote_mac_i  (remote_mac),
        .tx_data_i     (tx_data_i),
        .tx_addr_o     (tx_addr_o),
        .frame_done_o  (frame_done),
        .gmii_tx_en_o  (gmii_tx_en_o),
        .gmii_txd_o    (gmii_txd_o)
    );

    arp_rx_parser #(
        .LOCAL_IP  (LOCAL_IP),
        .REMOTE_IP (REMOTE_IP)
    ) arp_rx_parser_i (
        .gmii_tx_clk  (gmii_tx_clk),
        .rst_n        (rst_n),
        .gmii_rx_dv_i (gmii_rx_dv_i),
        .gmii_rxd_i   (gmii_rxd_i),
        .arp_found_o  (arp_found),
        .remote_mac_o (remote_mac),
        .mac_valid_o  (mac_valid)
    );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial
    begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1; // released away from the active edge
    end

endmodule

//--- verification/udp_mac_chk.sv
`timescale 1ns/10ps

module udp_mac_chk import seg_pkg::*; (
    input logic             gmii_tx_clk,
    input logic             rst_n,
    input logic             frame_start_i,
    input logic             frame_done_i,
    input logic             frame_kind_i,
    input logic [LEN_W-1:0] seg_len_i,
    input logic [LEN_W-1:0] seg_addr_i,
    input logic [LEN_W-1:0] tx_addr_i,
    input logic             gmii_tx_en_i,
    input logic             tx_done_i
);

    logic             busy;
    logic [LEN_W-1:0] addr_ofs;

    assign addr_ofs = tx_addr_i - seg_addr_i; // wraps like the RAM address

    always_ff @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
            busy <= 1'b0;
        else if (frame_start_i)
            busy <= 1'b1;
        else if (frame_done_i)
            busy <= 1'b0;
    end

    reset_quiet: assert property (@(posedge gmii_tx_clk)
        !rst_n |-> (!gmii_tx_en_i && !tx_done_i))
        else $error("tx enable or done high during reset");

    no_overlap: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
        frame_start_i |-> !busy)
        else $error("frame start while a frame is active");

    addr_range: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
        (busy && frame_kind_i == FRAME_UDP) |-> (addr_ofs < seg_len_i))
        else $error("RAM address outside the segment");

endmodule

//--- verification/udp_mac_tb.sv
`timescale 1ns/10ps

module udp_mac_tb;

    localparam logic [47:0] LOCAL_MAC   = 48'h000a_3501_fec0;
    localparam logic [31:0] LOCAL_IP    = 32'hc0a8_16c8;
    localparam logic [31:0] REMOTE_IP   = 32'hc0a8_1664;
    localparam logic [15:0] UDP_PORT    = 16'h1f90;
    localparam int          MAX_PAYLOAD = 64;
    localparam int          GAP_CYCLES  = 12;
    localparam int          ARP_TIMEOUT = 400;
    localparam logic [47:0] PEER_MAC    = 48'h0212_3456_789a;
    localparam logic [47:0] WRONG_MAC   = 48'h02ee_eeee_ee01;
    localparam int          N_SENDS     = 7;

    logic        clk;
    logic        rst_n;
    logic        tx_send_i;
    logic [15:0] tx_len_i;
    logic [15:0] tx_addr_i;
    logic [7:0]  tx_data_i;
    logic        gmii_rx_dv_i;
    logic [7:0]  gmii_rxd_i;
    logic [15:0] tx_addr_o;
    logic        tx_done_o;
    logic        gmii_tx_en_o;
    logic [7:0]  gmii_txd_o;

    logic [7:0]  ram [0:65535];
    logic [15:0] ram_addr_d;
    logic [7:0]  frm_q [$];    // dest MAC through padding
    logic [7:0]  out_q [$];    // full frame with preamble and FCS
    logic [7:0]  got_q [$];
    logic [15:0] ident_n;
    int          cycles;
    int          cycle_limit;
    int          frame_first;
    int          frame_end;
    int          prev_end;
    int          lens [N_SENDS];
    logic [15:0] addrs [N_SENDS];

    tb_clk_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(4)) tb_clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    udp_mac_top #(
        .LOCAL_MAC   (LOCAL_MAC),
        .LOCAL_IP    (LOCAL_IP),
        .REMOTE_IP   (REMOTE_IP),
        .UDP_PORT    (UDP_PORT),
        .MAX_PAYLOAD (MAX_PAYLOAD),
        .GAP_CYCLES  (GAP_CYCLES),
        .ARP_TIMEOUT (ARP_TIMEOUT)
    ) udp_mac_top_i (
        .gmii_tx_clk  (clk),
        .rst_n        (rst_n),
        .tx_send_i    (tx_send_i),
        .tx_len_i     (tx_len_i),
        .tx_addr_i    (tx_addr_i),
        .tx_data_i    (tx_data_i),
        .gmii_rx_dv_i (gmii_rx_dv_i),
        .gmii_rxd_i   (gmii_rxd_i),
        .tx_addr_o    (tx_addr_o),
        .tx_done_o    (tx_done_o),
        .gmii_tx_en_o (gmii_tx_en_o),
        .gmii_txd_o   (gmii_txd_o)
    );

    bind udp_mac_top udp_mac_chk udp_mac_chk_i (
        .gmii_tx_clk   (gmii_tx_clk),
        .rst_n         (rst_n),
        .frame_start_i (frame_start),
        .frame_done_i  (frame_done),
        .frame_kind_i  (frame_kind),
        .seg_len_i     (seg_len),
        .seg_addr_i    (seg_addr),
        .tx_addr_i     (tx_addr_o),
        .gmii_tx_en_i  (gmii_tx_en_o),
        .tx_done_i     (tx_done_o)
    );

    // synchronous RAM returns data one cycle after the address
    always @(negedge clk)
    begin
        tx_data_i  = ram[ram_addr_d];
        ram_addr_d = tx_addr_o;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic push_bytes(input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--)
            frm_q.push_back(v[8*i +: 8]); // network order with msb first
    endtask

    // pads frm_q and appends the reflected CRC-32 FCS low byte first
    task automatic wrap_frame();
        logic [31:0] crc;
        crc = 32'hffff_ffff;
        while (frm_q.size() < 60)
            frm_q.push_back(8'h00);
        foreach (frm_q[k])
        begin
            crc = crc ^ {24'h0, frm_q[k]};
            for (int b = 0; b < 8; b++)
                crc = crc[0] ? ((crc >> 1) ^ 32'hedb8_8320) : (crc >> 1);
        end
        crc = ~crc;
        out_q.delete();
        for (int i = 0; i < 7; i++)
            out_q.push_back(8'h55);
        out_q.push_back(8'hd5);
        foreach (frm_q[k])
            out_q.push_back(frm_q[k]);
        for (int i = 0; i < 4; i++)
            out_q.push_back(crc[8*i +: 8]);
    endtask

    task automatic build_arp_request();
        frm_q.delete();
        push_bytes(48'hffff_ffff_ffff, 6);
        push_bytes(LOCAL_MAC, 6);
        push_bytes(48'h0806, 2);
        push_bytes(48'h0001_0800_0604, 6);
        push_bytes(48'h0001, 2); // request
        push_bytes(LOCAL_MAC, 6);
        push_bytes({16'h0, LOCAL_IP}, 4);
        push_bytes(48'h0, 6);
        push_bytes({16'h0, REMOTE_IP}, 4);
        wrap_frame();
    endtask

    task automatic build_udp(input int len, input logic [15:0] addr);
        logic [31:0] sum;
        logic [15:0] total;
        logic [15:0] a;
        total = 16'(28 + len);
        sum = 32'h4500 + {16'h0, total} + {16'h0, ident_n} + 32'h4000 + 32'h8011
            + {16'h0, LOCAL_IP[31:16]} + {16'h0, LOCAL_IP[15:0]}
            + {16'h0, REMOTE_IP[31:16]} + {16'h0, REMOTE_IP[15:0]};
        while (sum[31:16] != 16'h0)
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        frm_q.delete();
        push_bytes(PEER_MAC, 6);
        push_bytes(LOCAL_MAC, 6);
        push_bytes(48'h0800, 2);
        push_bytes({32'h0, 16'h4500}, 2);
        push_bytes({32'h0, total}, 2);
        push_bytes({32'h0, ident_n}, 2);
        push_bytes(48'h4000_8011, 4); // DF, TTL 128, UDP
        push_bytes({32'h0, ~sum[15:0]}, 2);
        push_bytes({16'h0, LOCAL_IP}, 4);
        push_bytes({16'h0, REMOTE_IP}, 4);
        push_bytes({16'h0, UDP_PORT, UDP_PORT}, 4);
        push_bytes({32'h0, 16'(8 + len)}, 2);
        push_bytes(48'h0, 2); // no UDP checksum
        for (int i = 0; i < len; i++)
        begin
            a = addr + 16'(i);
            frm_q.push_back(ram[a]);
        end
        wrap_frame();
    endtask

    task automatic receive_frame();
        got_q.delete();
        @(negedge clk);
        while (!gmii_tx_en_o)
            @(negedge clk);
        frame_first = cycles;
        check_equal(64'(tx_done_o), 64'(0), "tx_done_o during a send");
        while (gmii_tx_en_o)
        begin
            got_q.push_back(gmii_txd_o);
            @(negedge clk);
        end
        frame_end = cycles;
    endtask

    task automatic compare_frame(input string kind);
        check_equal(64'(got_q.size()), 64'(out_q.size()), {kind, " frame length"});
        foreach (out_q[k])
            check_equal(64'(got_q[k]), 64'(out_q[k]), $sformatf("%s byte %0d", kind, k));
    endtask

    task automatic expect_udp(input int len, input logic [15:0] addr);
        build_udp(len, addr);
        receive_frame();
        compare_frame("udp");
        check_equal(64'(frame_first - prev_end >= GAP_CYCLES), 64'(1), "inter-frame gap");
        prev_end = frame_end;
        ident_n  = ident_n + 16'd1;
    endtask

    task automatic send_reply(input logic [31:0] sip, input logic [47:0] smac);
        frm_q.delete();
        push_bytes(LOCAL_MAC, 6);
        push_bytes(smac, 6);
        push_bytes(48'h0806, 2);
        push_bytes(48'h0001_0800_0604, 6);
        push_bytes(48'h0002, 2); // reply
        push_bytes(smac, 6);
        push_bytes({16'h0, sip}, 4);
        push_bytes(LOCAL_MAC, 6);
        push_bytes({16'h0, LOCAL_IP}, 4);
        wrap_frame();
        foreach (out_q[k])
        begin
            @(negedge clk);
            gmii_rx_dv_i = 1'b1;
            gmii_rxd_i   = out_q[k];
            check_equal(64'(gmii_tx_en_o), 64'(0), "frame sent before the ARP reply");
        end
        @(negedge clk);
        gmii_rx_dv_i = 1'b0;
        gmii_rxd_i   = 8'h00;
        repeat (4) @(negedge clk);
    endtask

    task automatic start_send(input int len, input logic [15:0] addr);
        repeat (4) @(negedge clk);
        tx_len_i  = 16'(len);
        tx_addr_i = addr;
        tx_send_i = 1'b1;
        while (tx_done_o)
            @(negedge clk);
    endtask

    task automatic send_segments(input int len, input logic [15:0] addr);
        int          rem;
        int          seg;
        logic [15:0] a;
        rem = len;
        a   = addr;
        while (rem > 0)
        begin
            seg = (rem > MAX_PAYLOAD) ? MAX_PAYLOAD : rem;
            expect_udp(seg, a);
            a   = a + 16'(seg);
            rem = rem - seg;
        end
        while (!tx_done_o)
        begin
            check_equal(64'(gmii_tx_en_o), 64'(0), "frame before tx_done_o");
            @(negedge clk);
        end
        check_equal(64'(cycles - prev_end >= GAP_CYCLES), 64'(1), "tx_done_o before the gap");
        tx_send_i = 1'b0;
    endtask

    initial
    begin
        int nframes;
        tx_send_i    = 1'b0;
        tx_len_i     = 16'h0;
        tx_addr_i    = 16'h0;
        tx_data_i    = 8'h00;
        gmii_rx_dv_i = 1'b0;
        gmii_rxd_i   = 8'h00;
        ram_addr_d   = 16'h0;
        ident_n      = 16'h0;
        cycles       = 0;
        prev_end     = 0;
        void'($urandom(32'hd05e_153c));
        for (int i = 0; i < 65536; i++)
            ram[i] = 8'($urandom);
        lens[0] = 1 + int'($urandom % 300);
        lens[1] = 1;
        lens[2] = MAX_PAYLOAD;
        lens[3] = 2 * MAX_PAYLOAD;
        lens[4] = 0;
        lens[5] = 1 + int'($urandom % 400);
        lens[6] = 1 + int'($urandom % 200);
        nframes = 0;
        for (int i = 0; i < N_SENDS; i++)
        begin
            addrs[i] = 16'($urandom);
            nframes  = nframes + (lens[i] + MAX_PAYLOAD - 1) / MAX_PAYLOAD;
        end
        // UDP frames, two ARP waits, two requests, two replies and setup per send
        cycle_limit = nframes * (122 + GAP_CYCLES + 10) + 2 * ARP_TIMEOUT
                    + 4 * 140 + N_SENDS * 40 + 200;

        @(posedge rst_n);
        start_send(lens[0], addrs[0]);
        build_arp_request();
        receive_frame();
        compare_frame("arp request");
        prev_end = frame_end;
        receive_frame();
        compare_frame("arp retry");
        check_equal(64'(frame_first - prev_end >= ARP_TIMEOUT), 64'(1), "ARP retry delay");
        send_reply(REMOTE_IP ^ 32'h1, WRONG_MAC);
        send_reply(REMOTE_IP, PEER_MAC);
        prev_end = frame_end;
        send_segments(lens[0], addrs[0]);

        for (int i = 1; i < N_SENDS; i++)
        begin
            start_send(lens[i], addrs[i]);
            send_segments(lens[i], addrs[i]);
        end
        repeat (20)
        begin
            @(negedge clk);
            check_equal(64'(gmii_tx_en_o), 64'(0), "frame after the last send");
        end

        $display("test passed");
        $finish;
    end

endmodule

//--- filelist.f
logic/net_pkg.sv
logic/seg_pkg.sv
logic/udp_tx_ctrl.sv
logic/frame_builder.sv
logic/arp_rx_parser.sv
logic/udp_mac_top.sv
verification/tb_clk_gen.sv
verification/udp_mac_chk.sv
verification/udp_mac_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= udp_mac_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
